//--- hdl/cache_defines.svh
`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

// Processor byte address and data word
`define CACHE_ADDR_W 16
`define CACHE_WORD_W 32

// Line geometry with four words per line
`define CACHE_LINE_WORDS 4
`define CACHE_LINE_W 128

// Address split where bits 1:0 select a byte and are ignored
`define CACHE_OFFSET_W 2
`define CACHE_INDEX_W 4
`define CACHE_TAG_W 8

// Backing store latency from start of an operation to its done pulse
`define MEM_LATENCY 4

`endif

//--- hdl/cache_pkg.sv
package cache_pkg;

    // Controller FSM states
    typedef enum logic [2:0] {
        IDLE,
        CMP_RD,
        CMP_WR,
        MEM_WB,
        MEM_RD,
        REFILL
    } ctrl_state_t;

    // Operation requested from the backing memory
    typedef enum logic [1:0] {
        OP_NONE,
        OP_READ,
        OP_WRITE
    } host_op_t;

endpackage

//--- hdl/cache_array.sv
`timescale 1ns/10ps
`include "cache_defines.svh"

module cache_array (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       cache_en,
    input  logic                       comp,
    input  logic                       wr_cache,
    input  logic                       replace_line,
    input  logic [`CACHE_INDEX_W-1:0]  index,
    input  logic [`CACHE_OFFSET_W-1:0] offset,
    input  logic [`CACHE_TAG_W-1:0]    tag_out,
    input  logic [`CACHE_WORD_W-1:0]   data_to_cache,
    input  logic [`CACHE_LINE_W-1:0]   line_to_cache,
    output logic                       hit_in,
    output logic                       valid_in,
    output logic                       dirty_in,
    output logic [`CACHE_TAG_W-1:0]    victim_tag,
    output logic [`CACHE_WORD_W-1:0]   data_from_cache,
    output logic [`CACHE_LINE_W-1:0]   line_from_cache
);
    localparam int SETS = 1 << `CACHE_INDEX_W;

    logic [SETS-1:0]                                 valid;
    logic [SETS-1:0]                                 dirty;
    logic [`CACHE_TAG_W-1:0]                         tag_mem [SETS];
    logic [`CACHE_LINE_WORDS-1:0][`CACHE_WORD_W-1:0] data_mem [SETS];

    logic fill_wr;
    logic word_wr;

    // Set is read combinationally at the current index
    assign valid_in        = valid[index];
    assign dirty_in        = dirty[index];
    assign victim_tag      = tag_mem[index];
    assign line_from_cache = data_mem[index];
    assign data_from_cache = data_mem[index][offset];
    assign hit_in          = cache_en && valid[index] && (tag_mem[index] == tag_out);

    assign fill_wr = cache_en && wr_cache && replace_line;
    assign word_wr = cache_en && wr_cache && comp && hit_in;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid <= '0;
            dirty <= '0;
        end else if (fill_wr) begin
            // Fresh line matches memory
            valid[index] <= 1'b1;
            dirty[index] <= 1'b0;
        end else if (word_wr) begin
            dirty[index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_wr) begin
            tag_mem[index]  <= tag_out;
            data_mem[index] <= line_to_cache;
        end else if (word_wr) begin
            data_mem[index][offset] <= data_to_cache;
        end
    end

    a_fill_not_compare: assert property (@(posedge clk) disable iff (!rst_n)
        !(replace_line && comp));

endmodule

//--- hdl/line_memory.sv
`timescale 1ns/10ps
`include "cache_defines.svh"

module line_memory (
    input  logic                     clk,
    input  logic                     rst_n,
    input  cache_pkg::host_op_t      op_host,
    input  logic [`CACHE_ADDR_W-1:0] addr_host,
    input  logic [`CACHE_LINE_W-1:0] line_to_host,
    output logic                     tx_done,
    output logic [`CACHE_LINE_W-1:0] line_from_host
);
    // One entry per cache line of the address space
    localparam int LINE_ADDR_W = `CACHE_TAG_W + `CACHE_INDEX_W;
    localparam int DEPTH       = 1 << LINE_ADDR_W;
    localparam int CNT_W       = $clog2(`MEM_LATENCY);

    logic [`CACHE_LINE_W-1:0] mem [DEPTH];
    logic                     busy;
    logic [CNT_W-1:0]         cnt;
    logic                     is_write;
    logic [LINE_ADDR_W-1:0]   line_addr;
    logic                     start;
    logic                     finish;

    // op_host is still held during the done cycle, so no restart then
    assign start  = (op_host != cache_pkg::OP_NONE) && !busy && !tx_done;
    assign finish = busy && (cnt == '0);

    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy    <= 1'b0;
            cnt     <= '0;
            tx_done <= 1'b0;
        end else begin
            tx_done <= finish;
            if (start) begin
                busy <= 1'b1;
                cnt  <= CNT_W'(`MEM_LATENCY - 2);
            end else if (finish) begin
                busy <= 1'b0;
            end else if (busy) begin
                cnt <= cnt - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            line_addr <= addr_host[`CACHE_ADDR_W-1 -: LINE_ADDR_W];
            is_write  <= (op_host == cache_pkg::OP_WRITE);
        end
        if (finish && !is_write) begin
            line_from_host <= mem[line_addr];
        end
    end

    always @(posedge clk) begin
        if (finish && is_write) begin
            mem[line_addr] <= line_to_host;
        end
    end

    a_done_single: assert property (@(posedge clk) disable iff (!rst_n)
        tx_done |=> !tx_done);

endmodule

//--- hdl/cache_ctrl.sv
`timescale 1ns/10ps
`include "cache_defines.svh"

module cache_ctrl (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [`CACHE_ADDR_W-1:0]   addr,
    input  logic [`CACHE_WORD_W-1:0]   wdata,
    input  logic                       rd,
    input  logic                       wr,
    input  logic                       hit_in,
    input  logic                       valid_in,
    input  logic                       dirty_in,
    input  logic [`CACHE_TAG_W-1:0]    victim_tag,
    input  logic [`CACHE_WORD_W-1:0]   data_from_cache,
    input  logic [`CACHE_LINE_W-1:0]   line_from_cache,
    input  logic                       tx_done,
    input  logic [`CACHE_LINE_W-1:0]   line_from_host,
    output logic [`CACHE_WORD_W-1:0]   rdata,
    output logic                       done,
    output logic                       hit,
    output logic                       stall,
    output logic                       cache_en,
    output logic                       comp,
    output logic                       wr_cache,
    output logic                       replace_line,
    output logic [`CACHE_INDEX_W-1:0]  index,
    output logic [`CACHE_OFFSET_W-1:0] offset,
    output logic [`CACHE_TAG_W-1:0]    tag_out,
    output logic [`CACHE_WORD_W-1:0]   data_to_cache,
    output logic [`CACHE_LINE_W-1:0]   line_to_cache,
    output logic [`CACHE_ADDR_W-1:0]   addr_host,
    output cache_pkg::host_op_t        op_host,
    output logic [`CACHE_LINE_W-1:0]   line_to_host
);
    // Field positions inside the byte address
    localparam int OFF_LO = 2;
    localparam int IDX_LO = OFF_LO + `CACHE_OFFSET_W;
    localparam int TAG_LO = IDX_LO + `CACHE_INDEX_W;

    cache_pkg::ctrl_state_t state;
    cache_pkg::ctrl_state_t next_state;

    logic [`CACHE_ADDR_W-1:0] req_addr;
    logic [`CACHE_WORD_W-1:0] req_wdata;
    logic                     req_write;
    logic                     miss_seen;
    logic [`CACHE_LINE_W-1:0] fill_line;
    logic                     accept;

    assign accept = (state == cache_pkg::IDLE) && (rd || wr);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= cache_pkg::IDLE;
            req_write <= 1'b0;
            miss_seen <= 1'b0;
        end else begin
            state <= next_state;
            if (accept) begin
                // A read wins when both strobes arrive together
                req_write <= !rd;
                miss_seen <= 1'b0;
            end else if ((state == cache_pkg::CMP_RD || state == cache_pkg::CMP_WR) &&
                         !hit_in) begin
                miss_seen <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_addr  <= addr;
            req_wdata <= wdata;
        end
        // Read line is only valid in the tx_done cycle
        if (state == cache_pkg::MEM_RD && tx_done) begin
            fill_line <= line_from_host;
        end
    end

    assign tag_out       = req_addr[TAG_LO +: `CACHE_TAG_W];
    assign index         = req_addr[IDX_LO +: `CACHE_INDEX_W];
    assign offset        = req_addr[OFF_LO +: `CACHE_OFFSET_W];
    assign data_to_cache = req_wdata;
    assign line_to_cache = fill_line;
    assign line_to_host  = line_from_cache;
    assign stall         = (state != cache_pkg::IDLE);

    // Victim goes back to where it came from, not to the request line
    assign addr_host = (state == cache_pkg::MEM_WB) ?
                       {victim_tag, index, {IDX_LO{1'b0}}} :
                       {tag_out, index, {IDX_LO{1'b0}}};

    always_comb begin
        next_state   = state;
        cache_en     = 1'b0;
        comp         = 1'b0;
        wr_cache     = 1'b0;
        replace_line = 1'b0;
        done         = 1'b0;
        hit          = 1'b0;
        rdata        = '0;
        op_host      = cache_pkg::OP_NONE;
        case (state)
            cache_pkg::IDLE: begin
                if (rd) begin
                    next_state = cache_pkg::CMP_RD;
                end else if (wr) begin
                    next_state = cache_pkg::CMP_WR;
                end
            end
            cache_pkg::CMP_RD, cache_pkg::CMP_WR: begin
                cache_en = 1'b1;
                comp     = 1'b1;
                wr_cache = (state == cache_pkg::CMP_WR);
                if (hit_in) begin
                    done       = 1'b1;
                    hit        = !miss_seen;
                    rdata      = (state == cache_pkg::CMP_RD) ? data_from_cache : '0;
                    next_state = cache_pkg::IDLE;
                end else if (valid_in && dirty_in) begin
                    next_state = cache_pkg::MEM_WB;
                end else begin
                    next_state = cache_pkg::MEM_RD;
                end
            end
            cache_pkg::MEM_WB: begin
                op_host = cache_pkg::OP_WRITE;
                if (tx_done) begin
                    next_state = cache_pkg::MEM_RD;
                end
            end
            cache_pkg::MEM_RD: begin
                op_host = cache_pkg::OP_READ;
                if (tx_done) begin
                    next_state = cache_pkg::REFILL;
                end
            end
            cache_pkg::REFILL: begin
                cache_en     = 1'b1;
                wr_cache     = 1'b1;
                replace_line = 1'b1;
                // Recompare so the request finishes through the hit path
                next_state   = req_write ? cache_pkg::CMP_WR : cache_pkg::CMP_RD;
            end
            default: begin
                next_state = cache_pkg::IDLE;
            end
        endcase
    end

    a_op_only_in_mem: assert property (@(posedge clk) disable iff (!rst_n)
        op_host != cache_pkg::OP_NONE |->
        (state == cache_pkg::MEM_WB || state == cache_pkg::MEM_RD));

    // Completion must come from a real tag match in the array
    a_done_needs_hit: assert property (@(posedge clk) disable iff (!rst_n)
        done |-> (valid_in && (victim_tag == tag_out)));

endmodule

//--- hdl/cache_subsystem.sv
`timescale 1ns/10ps
`include "cache_defines.svh"

module cache_subsystem (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [`CACHE_ADDR_W-1:0] addr,
    input  logic [`CACHE_WORD_W-1:0] wdata,
    input  logic                     rd,
    input  logic                     wr,
    output logic [`CACHE_WORD_W-1:0] rdata,
    output logic                     done,
    output logic                     hit,
    output logic                     stall
);
    // Controller and array
    logic                       cache_en;
    logic                       comp;
    logic                       wr_cache;
    logic                       replace_line;
    logic [`CACHE_INDEX_W-1:0]  index;
    logic [`CACHE_OFFSET_W-1:0] offset;
    logic [`CACHE_TAG_W-1:0]    tag_out;
    logic [`CACHE_WORD_W-1:0]   data_to_cache;
    logic [`CACHE_LINE_W-1:0]   line_to_cache;
    logic                       hit_in;
    logic                       valid_in;
    logic                       dirty_in;
    logic [`CACHE_TAG_W-1:0]    victim_tag;
    logic [`CACHE_WORD_W-1:0]   data_from_cache;
    logic [`CACHE_LINE_W-1:0]   line_from_cache;

    // Controller and backing memory
    cache_pkg::host_op_t        op_host;
    logic [`CACHE_ADDR_W-1:0]   addr_host;
    logic [`CACHE_LINE_W-1:0]   line_to_host;
    logic                       tx_done;
    logic [`CACHE_LINE_W-1:0]   line_from_host;

    cache_ctrl i_cache_ctrl (
        .clk             (clk),
        .rst_n           (rst_n),
        .addr            (addr),
        .wdata           (wdata),
        .rd              (rd),
        .wr              (wr),
        .hit_in          (hit_in),
        .valid_in        (valid_in),
        .dirty_in        (dirty_in),
        .victim_tag      (victim_tag),
        .data_from_cache (data_from_cache),
        .line_from_cache (line_from_cache),
        .tx_done         (tx_done),
        .line_from_host  (line_from_host),
        .rdata           (rdata),
        .done            (done),
        .hit             (hit),
        .stall           (stall),
        .cache_en        (cache_en),
        .comp            (comp),
        .wr_cache        (wr_cache),
        .replace_line    (replace_line),
        .index           (index),
        .offset          (offset),
        .tag_out         (tag_out),
        .data_to_cache   (data_to_cache),
        .line_to_cache   (line_to_cache),
        .addr_host       (addr_host),
        .op_host         (op_host),
        .line_to_host    (line_to_host)
    );

    cache_array i_cache_array (
        .clk             (clk),
        .rst_n           (rst_n),
        .cache_en        (cache_en),
        .comp            (comp),
        .wr_cache        (wr_cache),
        .replace_line    (replace_line),
        .index           (index),
        .offset          (offset),
        .tag_out         (tag_out),
        .data_to_cache   (data_to_cache),
        .line_to_cache   (line_to_cache),
        .hit_in          (hit_in),
        .valid_in        (valid_in),
        .dirty_in        (dirty_in),
        .victim_tag      (victim_tag),
        .data_from_cache (data_from_cache),
        .line_from_cache (line_from_cache)
    );

    line_memory i_line_memory (
        .clk            (clk),
        .rst_n          (rst_n),
        .op_host        (op_host),
        .addr_host      (addr_host),
        .line_to_host   (line_to_host),
        .tx_done        (tx_done),
        .line_from_host (line_from_host)
    );

endmodule

//--- tb/tb_cache_subsystem.sv
`timescale 1ns/10ps
`include "cache_defines.svh"

module tb_cache_subsystem;
    localparam int CLK_HALF   = 20;
    localparam int DRIVE_DLY  = 2;
    localparam int WAIT_LIMIT = 64;

    logic                     clk;
    logic                     rst_n;
    logic [`CACHE_ADDR_W-1:0] addr;
    logic [`CACHE_WORD_W-1:0] wdata;
    logic                     rd;
    logic                     wr;
    logic [`CACHE_WORD_W-1:0] rdata;
    logic                     done;
    logic                     hit;
    logic                     stall;

    int errors;
    int timeouts;
    int requests;
    bit hung;

    cache_subsystem i_cache_subsystem (
        .clk   (clk),
        .rst_n (rst_n),
        .addr  (addr),
        .wdata (wdata),
        .rd    (rd),
        .wr    (wr),
        .rdata (rdata),
        .done  (done),
        .hit   (hit),
        .stall (stall)
    );

    always #CLK_HALF clk = ~clk;

    // Sample at the falling edge until the controller is back in IDLE
    task automatic wait_idle(input int req_num);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (stall && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (stall) begin
            $display("TIMEOUT at %0t: stall never dropped before request %0d", $time, req_num);
            timeouts++;
            hung = 1'b1;
        end
    endtask

    // One-cycle strobe driven just after the rising edge
    task automatic send_request(input bit is_write, input logic [`CACHE_ADDR_W-1:0] a,
                                input logic [`CACHE_WORD_W-1:0] d);
        @(posedge clk);
        #DRIVE_DLY;
        addr  = a;
        wdata = d;
        rd    = !is_write;
        wr    = is_write;
        @(posedge clk);
        #DRIVE_DLY;
        rd = 1'b0;
        wr = 1'b0;
    endtask

    // Stall must stay high on every cycle up to and including done
    task automatic wait_done(input int req_num, output bit got_done);
        int cycles;
        cycles   = 0;
        got_done = 1'b0;
        while (!got_done && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
            assert (stall === 1'b1) else begin
                $display("CHECK FAILED at %0t: req %0d stall got %b expected 1",
                         $time, req_num, stall);
                errors++;
            end
            got_done = (done === 1'b1);
        end
        if (!got_done) begin
            $display("TIMEOUT at %0t: request %0d never raised done", $time, req_num);
            timeouts++;
            hung = 1'b1;
        end
    endtask

    task automatic run_request(input bit is_write, input logic [`CACHE_ADDR_W-1:0] a,
                               input logic [`CACHE_WORD_W-1:0] d,
                               input logic [`CACHE_WORD_W-1:0] exp_rdata,
                               input logic exp_hit);
        bit got_done;
        int gap;
        requests++;
        wait_idle(requests);
        if (!hung) begin
            send_request(is_write, a, d);
            wait_done(requests, got_done);
            if (got_done) begin
                assert (hit === exp_hit) else begin
                    $display("CHECK FAILED at %0t: req %0d hit got %b expected %b",
                             $time, requests, hit, exp_hit);
                    errors++;
                end
                if (!is_write) begin
                    assert (rdata === exp_rdata) else begin
                        $display("CHECK FAILED at %0t: req %0d rdata got %h expected %h",
                                 $time, requests, rdata, exp_rdata);
                        errors++;
                    end
                end
                // Exactly one done pulse per request
                @(negedge clk);
                assert (done === 1'b0) else begin
                    $display("CHECK FAILED at %0t: req %0d done got %b expected 0",
                             $time, requests, done);
                    errors++;
                end
                gap = int'($urandom % 4);
                repeat (gap) @(posedge clk);
            end
        end
    endtask

    initial begin
        string                    op_tok;
        logic [`CACHE_ADDR_W-1:0] f_addr;
        logic [`CACHE_WORD_W-1:0] f_wdata;
        logic [`CACHE_WORD_W-1:0] f_rdata;
        logic                     f_hit;
        int                       fd;
        int                       code;
        int                       ch;
        clk      = 1'b0;
        rst_n    = 1'b0;
        addr     = '0;
        wdata    = '0;
        rd       = 1'b0;
        wr       = 1'b0;
        errors   = 0;
        timeouts = 0;
        requests = 0;
        hung     = 1'b0;
        void'($urandom(37));

        repeat (3) @(posedge clk);
        #DRIVE_DLY;
        rst_n = 1'b1;
        @(negedge clk);
        assert (stall === 1'b0) else begin
            $display("CHECK FAILED at %0t: stall got %b expected 0", $time, stall);
            errors++;
        end
        assert (done === 1'b0) else begin
            $display("CHECK FAILED at %0t: done got %b expected 0", $time, done);
            errors++;
        end

        fd = $fopen("tb/cache_golden.txt", "r");
        if (fd == 0) begin
            $display("Could not open the golden file tb/cache_golden.txt");
            errors++;
        end else begin
            code = $fscanf(fd, "%s", op_tok);
            while (code == 1 && !hung) begin
                if (op_tok[0] == "#") begin
                    // Skip the rest of a comment line
                    ch = $fgetc(fd);
                    while (ch != 10 && ch != -1) begin
                        ch = $fgetc(fd);
                    end
                end else if (op_tok != "R" && op_tok != "W") begin
                    $display("Unknown operation %s in the golden file", op_tok);
                    errors++;
                end else begin
                    code = $fscanf(fd, "%h %h %h %h", f_addr, f_wdata, f_rdata, f_hit);
                    if (code != 4) begin
                        $display("Golden file line after request %0d is malformed", requests);
                        errors++;
                    end else begin
                        run_request(op_tok == "W", f_addr, f_wdata, f_rdata, f_hit);
                    end
                end
                code = $fscanf(fd, "%s", op_tok);
            end
            $fclose(fd);
            if (requests == 0) begin
                $display("The golden file held no requests");
                errors++;
            end
        end

        $display("Summary: %0d requests, %0d check errors, %0d timeouts",
                 requests, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- cache_subsystem.f
+incdir+hdl
hdl/cache_pkg.sv
hdl/cache_array.sv
hdl/line_memory.sv
hdl/cache_ctrl.sv
hdl/cache_subsystem.sv
tb/tb_cache_subsystem.sv

//--- run_sim.sh
#!/bin/sh
# Compile the cache testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f cache_subsystem.f \
    --top-module tb_cache_subsystem --Mdir obj_dir -o sim_cache
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_cache)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Done: no errors"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1

//--- tb/cache_golden.txt
# op addr wdata exp_rdata exp_hit, all fields hex
# op is R for read or W for write, exp_rdata only checked on reads
R 0010 00000000 00000000 0
R 0014 00000000 00000000 1
W 0018 11111111 00000000 1
R 0018 00000000 11111111 1
W 0120 22222222 00000000 0
R 0120 00000000 22222222 1
R 012C 00000000 00000000 1
W 0210 33333333 00000000 0
R 0018 00000000 11111111 0
R 0210 00000000 33333333 0
W 0034 44444444 00000000 0
W 0038 55555555 00000000 1
R 0034 00000000 44444444 1
R 0038 00000000 55555555 1
W AB34 66666666 00000000 0
R AB34 00000000 66666666 1
R 0030 00000000 00000000 0
R 0038 00000000 55555555 1
R FFF0 00000000 00000000 0
R AB34 00000000 66666666 0
